// File: all.f
unpack_pkg.sv
operand_buffer.sv
operand_extract.sv
unpack_stage_ctrl.sv
vreg_unpack.sv
vreg_unpack_assertions.sv
vreg_unpack_tb.sv

// File: operand_buffer.sv
// --------------------
// operand buffer
// loads, shifts or holds one vector register
// --------------------

`timescale 1ns/1ns

module operand_buffer
    import unpack_pkg::*;
#(
    parameter bit IS_MASK = 1'b0
) (
    input  logic              clk_i,
    input  logic              adv_i,
    input  logic              valid_i,
    input  op_req_t           req_i,
    input  eew_e              eew_i,
    input  logic [VREG_W-1:0] vreg_data_i,
    output logic [VREG_W-1:0] buf_o
);

    logic [VREG_W-1:0] buf_q;
    logic [VREG_W-1:0] shifted;

    // next section of the register moves down, zero filled
    always_comb begin
        shifted = buf_q;
        if (IS_MASK) begin
            // one mask bit per element, 32 bytes of operand per item
            unique case (eew_i)
                EEW_8:   shifted = buf_q >> 32;
                EEW_16:  shifted = buf_q >> 16;
                EEW_32:  shifted = buf_q >> 8;
                default: shifted = buf_q;
            endcase
        end else begin
            // narrow items use only half of a word
            if (req_i.flags.narrow) begin
                shifted = buf_q >> 16;
            end else begin
                shifted = buf_q >> 32;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (adv_i && valid_i) begin
            if (req_i.load) begin
                buf_q <= vreg_data_i;
            end else if (!req_i.flags.hold) begin
                buf_q <= shifted;
            end
        end
    end

    assign buf_o = buf_q;

endmodule

// File: operand_extract.sv
// --------------------
// operand extraction
// slice, extend, broadcast or expand a mask,
// then register the operand
// --------------------

`timescale 1ns/1ns

module operand_extract
    import unpack_pkg::*;
#(
    parameter bit IS_MASK = 1'b0
) (
    input  logic              clk_i,
    input  logic              adv_i,
    input  logic [VREG_W-1:0] buf_i,
    input  op_req_t           req_i,
    input  eew_e              eew_i,
    output logic [OP_W-1:0]   op_data_o
);

    logic [OP_W-1:0] data_op;
    logic [OP_W-1:0] mask_op;
    logic [OP_W-1:0] op_d;

    // data operand
    always_comb begin
        data_op = '0;
        if (!req_i.flags.vreg) begin
            // scalar broadcast over all elements
            unique case (eew_i)
                EEW_8:   data_op = {4{req_i.xval[7:0]}};
                EEW_16:  data_op = {2{req_i.xval[15:0]}};
                EEW_32:  data_op = req_i.xval[31:0];
                default: data_op = '0;
            endcase
        end else if (req_i.flags.narrow) begin
            // half-width elements extended to the element width
            unique case (eew_i)
                EEW_16: begin
                    for (int j = 0; j < 2; j++) begin
                        data_op[16*j +: 16] = {
                            {8{req_i.flags.sigext & buf_i[8*j+7]}},
                            buf_i[8*j +: 8]
                        };
                    end
                end
                EEW_32: begin
                    data_op = {{16{req_i.flags.sigext & buf_i[15]}}, buf_i[15:0]};
                end
                default: data_op = '0;
            endcase
        end else begin
            data_op = buf_i[OP_W-1:0];
        end
    end

    // element mask to byte mask
    always_comb begin
        mask_op = '0;
        unique case (eew_i)
            EEW_8: begin
                mask_op = buf_i[OP_W-1:0];
            end
            EEW_16: begin
                for (int j = 0; j < OP_W/2; j++) begin
                    mask_op[2*j +: 2] = {2{buf_i[j]}};
                end
            end
            EEW_32: begin
                for (int j = 0; j < OP_W/4; j++) begin
                    mask_op[4*j +: 4] = {4{buf_i[j]}};
                end
            end
            default: mask_op = '0;
        endcase
    end

    assign op_d = IS_MASK ? mask_op : data_op;

    // output operand register of stage 2
    always_ff @(posedge clk_i) begin
        if (adv_i) begin
            op_data_o <= op_d;
        end
    end

endmodule

// File: unpack_pkg.sv
// --------------------
// shared widths and request types of the
// vector register operand unpacker
// --------------------

package unpack_pkg;

    // vector register file geometry
    localparam int unsigned VREG_W    = 64;
    localparam int unsigned VADDR_W   = 5;
    localparam int unsigned NUM_VREGS = 32;

    // operand and scalar widths
    localparam int unsigned OP_W   = 32;
    localparam int unsigned XVAL_W = 32;

    // operand count and operand index names
    localparam int unsigned NUM_OPS = 2;
    localparam int unsigned OP_DATA = 0;
    localparam int unsigned OP_MASK = 1;

    // element width of the current item
    typedef enum logic [1:0] {
        EEW_8  = 2'd0,
        EEW_16 = 2'd1,
        EEW_32 = 2'd2
    } eew_e;

    // per-operand unpack flags
    typedef struct packed {
        // operand comes from a vector register, else from the scalar
        logic vreg;
        // operand holds half-width elements
        logic narrow;
        // sign extension for narrow elements
        logic sigext;
        // buffer keeps its content
        logic hold;
    } op_flags_t;

    // request of one operand, 42 bits
    typedef struct packed {
        logic               load;
        logic [VADDR_W-1:0] vaddr;
        op_flags_t          flags;
        logic [XVAL_W-1:0]  xval;
    } op_req_t;

    // one item without its control bits, 86 bits
    typedef struct packed {
        eew_e                  eew;
        op_req_t [NUM_OPS-1:0] op;
    } unpack_req_t;

endpackage

// File: unpack_stage_ctrl.sv
// --------------------
// stage control of the unpacker
// valid bits, ready chain, read addressing
// and status flags
// --------------------

`timescale 1ns/1ns

module unpack_stage_ctrl
    import unpack_pkg::*;
#(
    parameter int unsigned CTRL_W = 4
) (
    input  logic                             clk_i,
    input  logic                             async_rst_ni,

    input  logic                             pipe_in_valid_i,
    input  unpack_req_t                      pipe_in_req_i,
    input  logic [CTRL_W-1:0]                pipe_in_ctrl_i,
    input  logic                             pipe_out_ready_i,

    output logic                             pipe_in_ready_o,
    output logic                             pipe_out_valid_o,
    output logic [CTRL_W-1:0]                pipe_out_ctrl_o,

    // stage advance strobes and stage 1 request
    output logic                             adv1_o,
    output logic                             adv2_o,
    output unpack_req_t                      stage1_req_o,

    output logic [NUM_OPS-1:0][VADDR_W-1:0]  vreg_rd_addr_o,
    output logic [NUM_VREGS-1:0]             pending_vreg_reads_o,
    output logic                             stage_valid_any_o,
    output logic [CTRL_W-1:0]                ctrl_flags_any_o,
    output logic [CTRL_W-1:0]                ctrl_flags_all_o
);

    logic              stage1_valid_q;
    logic              stage2_valid_q;
    logic [CTRL_W-1:0] stage1_ctrl_q;
    logic [CTRL_W-1:0] stage2_ctrl_q;
    unpack_req_t       stage1_req_q;

    logic stage1_ready;
    logic stage2_ready;
    logic in_accept;

    // a stage is ready when the next one is ready or when it holds nothing
    assign stage2_ready = pipe_out_ready_i | ~stage2_valid_q;
    assign stage1_ready = stage2_ready | ~stage1_valid_q;
    assign in_accept    = pipe_in_valid_i & stage1_ready;

    assign pipe_in_ready_o = stage1_ready;
    assign adv1_o          = stage1_ready;
    assign adv2_o          = stage2_ready;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            stage1_valid_q <= 1'b0;
            stage2_valid_q <= 1'b0;
        end else begin
            if (stage1_ready) begin
                stage1_valid_q <= in_accept;
            end
            if (stage2_ready) begin
                stage2_valid_q <= stage1_valid_q;
            end
        end
    end

    // request and control bits follow the valid bits
    always_ff @(posedge clk_i) begin
        if (stage1_ready) begin
            stage1_req_q  <= pipe_in_req_i;
            stage1_ctrl_q <= pipe_in_ctrl_i;
        end
        if (stage2_ready) begin
            stage2_ctrl_q <= stage1_ctrl_q;
        end
    end

    assign stage1_req_o     = stage1_req_q;
    assign pipe_out_valid_o = stage2_valid_q;
    assign pipe_out_ctrl_o  = stage2_ctrl_q;

    // operand i always reads over port i, addressed straight from the input
    always_comb begin
        for (int i = 0; i < NUM_OPS; i++) begin
            vreg_rd_addr_o[i] = pipe_in_req_i.op[i].vaddr;
        end
    end

    // loads only happen at input, so only the input item can have a read pending
    always_comb begin
        pending_vreg_reads_o = '0;
        for (int i = 0; i < NUM_OPS; i++) begin
            if (pipe_in_valid_i && pipe_in_req_i.op[i].load && pipe_in_req_i.op[i].flags.vreg) begin
                pending_vreg_reads_o[pipe_in_req_i.op[i].vaddr] = 1'b1;
            end
        end
    end

    // status over input, stage 1 and stage 2
    always_comb begin
        stage_valid_any_o = pipe_in_valid_i | stage1_valid_q | stage2_valid_q;
        ctrl_flags_any_o  = '0;
        ctrl_flags_all_o  = '1;
        if (pipe_in_valid_i) begin
            ctrl_flags_any_o = ctrl_flags_any_o | pipe_in_ctrl_i;
            ctrl_flags_all_o = ctrl_flags_all_o & pipe_in_ctrl_i;
        end
        if (stage1_valid_q) begin
            ctrl_flags_any_o = ctrl_flags_any_o | stage1_ctrl_q;
            ctrl_flags_all_o = ctrl_flags_all_o & stage1_ctrl_q;
        end
        if (stage2_valid_q) begin
            ctrl_flags_any_o = ctrl_flags_any_o | stage2_ctrl_q;
            ctrl_flags_all_o = ctrl_flags_all_o & stage2_ctrl_q;
        end
    end

endmodule

// File: vreg_unpack.sv
// --------------------
// vector register operand unpacker
// two-stage pipe from items to 32-bit operands
// --------------------

`timescale 1ns/1ns

module vreg_unpack
    import unpack_pkg::*;
#(
    parameter int unsigned CTRL_W = 4
) (
    input  logic                             clk_i,
    input  logic                             async_rst_ni,

    // input pipe
    input  logic                             pipe_in_valid_i,
    output logic                             pipe_in_ready_o,
    input  unpack_req_t                      pipe_in_req_i,
    input  logic [CTRL_W-1:0]                pipe_in_ctrl_i,

    // output pipe
    output logic                             pipe_out_valid_o,
    input  logic                             pipe_out_ready_i,
    output logic [CTRL_W-1:0]                pipe_out_ctrl_o,
    output logic [NUM_OPS-1:0][OP_W-1:0]     pipe_out_op_data_o,

    // register file read ports
    output logic [NUM_OPS-1:0][VADDR_W-1:0]  vreg_rd_addr_o,
    input  logic [NUM_OPS-1:0][VREG_W-1:0]   vreg_rd_data_i,

    // status
    output logic [NUM_VREGS-1:0]             pending_vreg_reads_o,
    output logic                             stage_valid_any_o,
    output logic [CTRL_W-1:0]                ctrl_flags_any_o,
    output logic [CTRL_W-1:0]                ctrl_flags_all_o
);

    logic              adv1;
    logic              adv2;
    unpack_req_t       stage1_req;
    logic [VREG_W-1:0] data_buf;
    logic [VREG_W-1:0] mask_buf;

    unpack_stage_ctrl #(
        .CTRL_W (CTRL_W)
    ) stage_ctrl0 (
        .clk_i                (clk_i),
        .async_rst_ni         (async_rst_ni),
        .pipe_in_valid_i      (pipe_in_valid_i),
        .pipe_in_req_i        (pipe_in_req_i),
        .pipe_in_ctrl_i       (pipe_in_ctrl_i),
        .pipe_out_ready_i     (pipe_out_ready_i),
        .pipe_in_ready_o      (pipe_in_ready_o),
        .pipe_out_valid_o     (pipe_out_valid_o),
        .pipe_out_ctrl_o      (pipe_out_ctrl_o),
        .adv1_o               (adv1),
        .adv2_o               (adv2),
        .stage1_req_o         (stage1_req),
        .vreg_rd_addr_o       (vreg_rd_addr_o),
        .pending_vreg_reads_o (pending_vreg_reads_o),
        .stage_valid_any_o    (stage_valid_any_o),
        .ctrl_flags_any_o     (ctrl_flags_any_o),
        .ctrl_flags_all_o     (ctrl_flags_all_o)
    );

    // data operand reads port 0, the mask operand port 1
    // buffers load from the incoming item, so adv1 with input valid is acceptance
    operand_buffer #(
        .IS_MASK (1'b0)
    ) data_buf0 (
        .clk_i       (clk_i),
        .adv_i       (adv1),
        .valid_i     (pipe_in_valid_i),
        .req_i       (pipe_in_req_i.op[OP_DATA]),
        .eew_i       (pipe_in_req_i.eew),
        .vreg_data_i (vreg_rd_data_i[OP_DATA]),
        .buf_o       (data_buf)
    );

    operand_buffer #(
        .IS_MASK (1'b1)
    ) mask_buf0 (
        .clk_i       (clk_i),
        .adv_i       (adv1),
        .valid_i     (pipe_in_valid_i),
        .req_i       (pipe_in_req_i.op[OP_MASK]),
        .eew_i       (pipe_in_req_i.eew),
        .vreg_data_i (vreg_rd_data_i[OP_MASK]),
        .buf_o       (mask_buf)
    );

    // extraction works on the stage 1 request and buffer
    operand_extract #(
        .IS_MASK (1'b0)
    ) data_ext0 (
        .clk_i     (clk_i),
        .adv_i     (adv2),
        .buf_i     (data_buf),
        .req_i     (stage1_req.op[OP_DATA]),
        .eew_i     (stage1_req.eew),
        .op_data_o (pipe_out_op_data_o[OP_DATA])
    );

    operand_extract #(
        .IS_MASK (1'b1)
    ) mask_ext0 (
        .clk_i     (clk_i),
        .adv_i     (adv2),
        .buf_i     (mask_buf),
        .req_i     (stage1_req.op[OP_MASK]),
        .eew_i     (stage1_req.eew),
        .op_data_o (pipe_out_op_data_o[OP_MASK])
    );

endmodule

// File: vreg_unpack_assertions.sv
// --------------------
// concurrent checks on the unpacker
// output handshake and status
// --------------------

`timescale 1ns/1ns

module vreg_unpack_assertions
    import unpack_pkg::*;
#(
    parameter int unsigned CTRL_W = 4
) (
    input logic                         clk_i,
    input logic                         async_rst_ni,
    input logic                         out_valid_i,
    input logic                         out_ready_i,
    input logic [CTRL_W-1:0]            out_ctrl_i,
    input logic [NUM_OPS-1:0][OP_W-1:0] out_op_data_i,
    input logic                         stage_valid_any_i
);

    // nothing leaves while reset is applied
    assert property (@(posedge clk_i) !async_rst_ni |-> !out_valid_i)
        else $error("output valid during reset");

    // a stalled output keeps its item
    assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        out_valid_i && !out_ready_i |=>
            out_valid_i && $stable(out_ctrl_i) && $stable(out_op_data_i))
        else $error("output changed while stalled");

    // an empty pipe with no input cannot produce an item in the next cycle
    assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        !stage_valid_any_i |=> !out_valid_i)
        else $error("output became valid although no stage held an item");

endmodule

// File: vreg_unpack_tb.sv
// --------------------
// testbench of the vector register operand unpacker
// random items checked against a reference model
// --------------------

`timescale 1ns/1ns

module vreg_unpack_tb
    import unpack_pkg::*;
();

    localparam int unsigned CTRL_W     = 4;
    localparam int unsigned N_ITEMS    = 400;
    localparam int unsigned MAX_CYCLES = 20 * N_ITEMS;

    // expected result of one item
    typedef struct packed {
        logic [CTRL_W-1:0]            ctrl;
        logic [NUM_OPS-1:0][OP_W-1:0] ops;
    } exp_item_t;

    logic                            clk_i;
    logic                            async_rst_ni;
    logic                            pipe_in_valid_i;
    logic                            pipe_in_ready_o;
    unpack_req_t                     pipe_in_req_i;
    logic [CTRL_W-1:0]               pipe_in_ctrl_i;
    logic                            pipe_out_valid_o;
    logic                            pipe_out_ready_i;
    logic [CTRL_W-1:0]               pipe_out_ctrl_o;
    logic [NUM_OPS-1:0][OP_W-1:0]    pipe_out_op_data_o;
    logic [NUM_OPS-1:0][VADDR_W-1:0] vreg_rd_addr_o;
    logic [NUM_OPS-1:0][VREG_W-1:0]  vreg_rd_data_i;
    logic [NUM_VREGS-1:0]            pending_vreg_reads_o;
    logic                            stage_valid_any_o;
    logic [CTRL_W-1:0]               ctrl_flags_any_o;
    logic [CTRL_W-1:0]               ctrl_flags_all_o;

    logic [VREG_W-1:0]              regfile [NUM_VREGS];
    logic [NUM_OPS-1:0][VREG_W-1:0] model_buf;
    exp_item_t                      exp_q [$];
    logic [31:0]                    rng_state;
    int unsigned                    cycle_cnt = 0;
    int unsigned                    sent_cnt;
    int unsigned                    recv_cnt;

    vreg_unpack #(
        .CTRL_W (CTRL_W)
    ) dut0 (
        .clk_i                (clk_i),
        .async_rst_ni         (async_rst_ni),
        .pipe_in_valid_i      (pipe_in_valid_i),
        .pipe_in_ready_o      (pipe_in_ready_o),
        .pipe_in_req_i        (pipe_in_req_i),
        .pipe_in_ctrl_i       (pipe_in_ctrl_i),
        .pipe_out_valid_o     (pipe_out_valid_o),
        .pipe_out_ready_i     (pipe_out_ready_i),
        .pipe_out_ctrl_o      (pipe_out_ctrl_o),
        .pipe_out_op_data_o   (pipe_out_op_data_o),
        .vreg_rd_addr_o       (vreg_rd_addr_o),
        .vreg_rd_data_i       (vreg_rd_data_i),
        .pending_vreg_reads_o (pending_vreg_reads_o),
        .stage_valid_any_o    (stage_valid_any_o),
        .ctrl_flags_any_o     (ctrl_flags_any_o),
        .ctrl_flags_all_o     (ctrl_flags_all_o)
    );

    bind vreg_unpack vreg_unpack_assertions #(
        .CTRL_W (CTRL_W)
    ) assertions0 (
        .clk_i             (clk_i),
        .async_rst_ni      (async_rst_ni),
        .out_valid_i       (pipe_out_valid_o),
        .out_ready_i       (pipe_out_ready_i),
        .out_ctrl_i        (pipe_out_ctrl_o),
        .out_op_data_i     (pipe_out_op_data_o),
        .stage_valid_any_i (stage_valid_any_o)
    );

    initial clk_i = 1'b0;
    always #4 clk_i = ~clk_i;

    // register file answers in the same cycle
    assign vreg_rd_data_i[OP_DATA] = regfile[vreg_rd_addr_o[OP_DATA]];
    assign vreg_rd_data_i[OP_MASK] = regfile[vreg_rd_addr_o[OP_MASK]];

    function automatic logic [31:0] rand32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic int unsigned eew_bits(eew_e e);
        case (e)
            EEW_8:   return 8;
            EEW_16:  return 16;
            default: return 32;
        endcase
    endfunction

    // bits consumed per item by one operand
    function automatic int unsigned advance_bits(int unsigned op, unpack_req_t req);
        if (op == OP_DATA) begin
            return req.op[op].flags.narrow ? 16 : 32;
        end
        return OP_W / (eew_bits(req.eew) / 8);
    endfunction

    function automatic logic [OP_W-1:0] expect_data(op_req_t r, eew_e e,
                                                    logic [VREG_W-1:0] b);
        logic [OP_W-1:0] res;
        int unsigned     ew;
        int unsigned     half;
        res  = '0;
        ew   = eew_bits(e);
        half = ew / 2;
        for (int k = 0; k < OP_W; k++) begin
            if (!r.flags.vreg) begin
                res[k] = r.xval[k % ew];
            end else if (!r.flags.narrow) begin
                res[k] = b[k];
            end else if (e != EEW_8) begin
                // element k/ew comes from half-width element k/ew of the buffer
                if (k % ew < half) begin
                    res[k] = b[(k / ew) * half + k % ew];
                end else begin
                    res[k] = r.flags.sigext & b[(k / ew) * half + half - 1];
                end
            end
        end
        return res;
    endfunction

    function automatic logic [OP_W-1:0] expect_mask(eew_e e, logic [VREG_W-1:0] b);
        logic [OP_W-1:0] res;
        int unsigned     rep;
        rep = eew_bits(e) / 8;
        for (int k = 0; k < OP_W; k++) begin
            res[k] = b[k / rep];
        end
        return res;
    endfunction

    function automatic void model_accept(unpack_req_t req, logic [CTRL_W-1:0] ctrl);
        exp_item_t item;
        for (int i = 0; i < NUM_OPS; i++) begin
            if (req.op[i].load) begin
                model_buf[i] = regfile[req.op[i].vaddr];
            end else if (!req.op[i].flags.hold) begin
                model_buf[i] = model_buf[i] >> advance_bits(i, req);
            end
        end
        item.ctrl          = ctrl;
        item.ops[OP_DATA]  = expect_data(req.op[OP_DATA], req.eew, model_buf[OP_DATA]);
        item.ops[OP_MASK]  = expect_mask(req.eew, model_buf[OP_MASK]);
        exp_q.push_back(item);
    endfunction

    function automatic unpack_req_t random_item(bit first);
        unpack_req_t req;
        logic [31:0] r;
        req.eew = eew_e'(2'(rand32() % 3));
        for (int i = 0; i < NUM_OPS; i++) begin
            r = rand32();
            req.op[i].load         = first | (r[1:0] == 2'd0);
            req.op[i].vaddr        = r[12:8];
            req.op[i].flags.vreg   = r[16] | r[17];
            req.op[i].flags.narrow = r[18];
            req.op[i].flags.sigext = r[19];
            req.op[i].flags.hold   = (r[21:20] == 2'd0);
            req.op[i].xval         = rand32();
        end
        return req;
    endfunction

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the pipe stopped delivering items",
                     cycle_cnt);
            abort_run();
        end
    end

    initial begin
        logic [31:0]          r;
        logic [NUM_VREGS-1:0] exp_pending;
        logic [CTRL_W-1:0]    exp_or;
        logic [CTRL_W-1:0]    exp_and;
        logic                 exp_any;
        logic                 in_acc;
        logic                 stalled;
        rng_state        = 32'h31213241;
        async_rst_ni     = 1'b0;
        pipe_in_valid_i  = 1'b0;
        pipe_in_req_i    = '0;
        pipe_in_ctrl_i   = '0;
        pipe_out_ready_i = 1'b0;
        model_buf        = '0;
        sent_cnt         = 0;
        recv_cnt         = 0;
        in_acc           = 1'b0;
        stalled          = 1'b0;
        for (int a = 0; a < NUM_VREGS; a++) begin
            regfile[a] = {rand32(), rand32()};
        end
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        async_rst_ni = 1'b1;

        while (recv_cnt < N_ITEMS) begin
            r = rand32();
            // an offered item stays on the input until it is taken
            if (!pipe_in_valid_i || in_acc) begin
                pipe_in_valid_i = (sent_cnt < N_ITEMS) && (r[1:0] != 2'd0);
                if (pipe_in_valid_i) begin
                    pipe_in_req_i  = random_item(sent_cnt == 0);
                    pipe_in_ctrl_i = r[11:8];
                end
            end
            pipe_out_ready_i = r[16] | r[17];
            #1;

            exp_pending = '0;
            exp_or      = '0;
            exp_and     = '1;
            for (int i = 0; i < NUM_OPS; i++) begin
                if (pipe_in_valid_i && pipe_in_req_i.op[i].load &&
                    pipe_in_req_i.op[i].flags.vreg) begin
                    exp_pending[pipe_in_req_i.op[i].vaddr] = 1'b1;
                end
                if (pipe_in_valid_i) begin
                    check_value("vreg_rd_addr_o", vreg_rd_addr_o[i],
                                pipe_in_req_i.op[i].vaddr);
                end
            end
            check_value("pending_vreg_reads_o", pending_vreg_reads_o, exp_pending);

            // status covers the input item and every item still in the pipe
            exp_any = pipe_in_valid_i || (exp_q.size() != 0);
            if (pipe_in_valid_i) begin
                exp_or  = exp_or | pipe_in_ctrl_i;
                exp_and = exp_and & pipe_in_ctrl_i;
            end
            foreach (exp_q[j]) begin
                exp_or  = exp_or | exp_q[j].ctrl;
                exp_and = exp_and & exp_q[j].ctrl;
            end
            check_value("stage_valid_any_o", stage_valid_any_o, exp_any);
            check_value("ctrl_flags_any_o", ctrl_flags_any_o, exp_or);
            check_value("ctrl_flags_all_o", ctrl_flags_all_o, exp_and);

            // with both stages full the input waits for the output
            check_value("pipe_in_ready_o", pipe_in_ready_o,
                        (exp_q.size() < 2) || pipe_out_ready_i);

            if (stalled) begin
                check_value("pipe_out_valid_o", pipe_out_valid_o, 1'b1);
            end
            if (pipe_out_valid_o) begin
                if (exp_q.size() == 0) begin
                    $display("output valid while no accepted item is in flight");
                    abort_run();
                end
                check_value("pipe_out_ctrl_o", pipe_out_ctrl_o, exp_q[0].ctrl);
                check_value("pipe_out_op_data_o[0]", pipe_out_op_data_o[OP_DATA],
                            exp_q[0].ops[OP_DATA]);
                check_value("pipe_out_op_data_o[1]", pipe_out_op_data_o[OP_MASK],
                            exp_q[0].ops[OP_MASK]);
            end

            stalled = pipe_out_valid_o && !pipe_out_ready_i;
            in_acc  = pipe_in_valid_i && pipe_in_ready_o;
            if (pipe_out_valid_o && pipe_out_ready_i) begin
                void'(exp_q.pop_front());
                recv_cnt++;
            end
            if (in_acc) begin
                model_accept(pipe_in_req_i, pipe_in_ctrl_i);
                sent_cnt++;
            end
            @(negedge clk_i);
        end

        // once every item is back the pipe must stay empty
        pipe_in_valid_i = 1'b0;
        repeat (4) begin
            #1;
            check_value("pipe_out_valid_o", pipe_out_valid_o, 1'b0);
            check_value("stage_valid_any_o", stage_valid_any_o, 1'b0);
            @(negedge clk_i);
        end
        $display("All checks passed");
        $finish;
    end

endmodule
